// ==== sim.f ====
+incdir+design
design/spi_frame_pkg.sv
design/byte_link_if.sv
design/spi_byte_engine.sv
design/frame_assembler.sv
design/frame_crc.sv
design/frame_checker.sv
design/spi_frame_port.sv
testbench/spi_frame_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI frame port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sim.f --top-module spi_frame_tb \
  --Mdir "$OBJ" -o spi_frame_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$OBJ/spi_frame_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -F -q "*** TEST PASSED ***" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

// ==== testbench/spi_frame_tb.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

// Directed tests for the SPI frame command port
module spi_frame_tb;

  // SCK half period in clk cycles
  localparam int HALF_CYCLES = 6;
  // About 30 frames of roughly 800 cycles plus margin
  localparam int TIMEOUT_CYCLES = 40000;

  logic                    clk;
  logic                    resetn;
  logic                    sck;
  logic                    cs_n;
  logic                    copi;
  logic                    cipo;
  logic                    cmd_ack;
  logic                    cmd_req;
  spi_frame_pkg::word_t    reply_data;
  spi_frame_pkg::payload_t cmd_payload;
  spi_frame_pkg::count_t   crc_err_count;
  spi_frame_pkg::count_t   overrun_count;

  int errors;
  int checks;
  int cycle_count;
  // Error counts predicted from the frames sent so far
  int exp_crc_errs;
  int exp_overruns;

  spi_frame_port DUT (
    .clk           (clk),
    .resetn        (resetn),
    .sck           (sck),
    .cs_n          (cs_n),
    .copi          (copi),
    .cipo          (cipo),
    .reply_data    (reply_data),
    .cmd_req       (cmd_req),
    .cmd_ack       (cmd_ack),
    .cmd_payload   (cmd_payload),
    .crc_err_count (crc_err_count),
    .overrun_count (overrun_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit in clock cycles
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // One clock step that ends at the input drive point
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // cmd_req must stay low for n cycles
  task automatic expect_no_req(input int n, input string context_msg);
    int i;
    for (i = 0; i < n; i++) begin
      next_cycle();
      checks++;
      assert (!cmd_req) else begin
        errors++;
        $display("Error at %0t: cmd_req rose %s", $time, context_msg);
      end
    end
  endtask

  // Bit serial CRC-8 reference over bytes 0 to 6, each byte MSB first
  function automatic spi_frame_pkg::byte_t crc8_ref(input spi_frame_pkg::payload_t payload);
    spi_frame_pkg::byte_t crc;
    logic                 feedback;
    int                   k;
    int                   b;
    crc = '0;
    for (k = 0; k < `SPI_FRAME_BYTES - 1; k++) begin
      for (b = `SPI_BYTE_W - 1; b >= 0; b--) begin
        feedback = crc[`SPI_BYTE_W-1] ^ payload[k*`SPI_BYTE_W + b];
        crc = {crc[`SPI_BYTE_W-2:0], 1'b0};
        if (feedback) begin
          crc = crc ^ `SPI_CRC_POLY;
        end
      end
    end
    return crc;
  endfunction

  // CRC byte goes last in the top of the word
  function automatic spi_frame_pkg::word_t build_frame(input spi_frame_pkg::payload_t payload);
    return {crc8_ref(payload), payload};
  endfunction

  // SPI mode 0 controller that sends nbytes of the frame and collects CIPO
  task automatic spi_transfer(input spi_frame_pkg::word_t frame, input int nbytes,
                              output spi_frame_pkg::word_t reply);
    int k;
    int b;
    reply = '0;
    cs_n = 1'b0;
    wait_cycles(HALF_CYCLES);
    for (k = 0; k < nbytes; k++) begin
      for (b = `SPI_BYTE_W - 1; b >= 0; b--) begin
        // COPI changes while SCK is low
        copi = frame[k*`SPI_BYTE_W + b];
        wait_cycles(HALF_CYCLES);
        // Sample just before the rising edge
        reply[k*`SPI_BYTE_W + b] = cipo;
        sck = 1'b1;
        wait_cycles(HALF_CYCLES);
        sck = 1'b0;
      end
    end
    wait_cycles(HALF_CYCLES);
    cs_n = 1'b1;
    copi = 1'b0;
    // Gap between frames
    wait_cycles(2 * HALF_CYCLES);
  endtask

  // Host side of the four-phase handshake
  task automatic serve_host(input spi_frame_pkg::payload_t expected);
    while (!cmd_req) next_cycle();
    check_value("cmd_payload", 64'(cmd_payload), 64'(expected));
    cmd_ack = 1'b1;
    while (cmd_req) next_cycle();
    cmd_ack = 1'b0;
    // Checker leaves RELEASE here
    next_cycle();
  endtask

  task automatic good_frame_flow();
    spi_frame_pkg::payload_t payload;
    spi_frame_pkg::word_t    reply;
    payload    = 56'h66_5544_3322_1100;
    reply_data = 64'h0123_4567_89ab_cdef;
    spi_transfer(build_frame(payload), `SPI_FRAME_BYTES, reply);
    check_value("reply", reply, reply_data);
    serve_host(payload);
    check_value("crc_err_count", 64'(crc_err_count), 64'd0);
    check_value("overrun_count", 64'(overrun_count), 64'd0);
  endtask

  task automatic bad_crc_drop();
    spi_frame_pkg::word_t frame;
    spi_frame_pkg::word_t reply;
    frame = build_frame(56'hde_adbe_ef01_2345);
    // Flip a few bits of the CRC byte
    frame[63:56] = frame[63:56] ^ 8'h5a;
    exp_crc_errs++;
    spi_transfer(frame, `SPI_FRAME_BYTES, reply);
    expect_no_req(50, "after a frame with a bad CRC");
    check_value("crc_err_count", 64'(crc_err_count), 64'(exp_crc_errs));
  endtask

  task automatic aborted_frame_recovery();
    spi_frame_pkg::payload_t payload;
    spi_frame_pkg::word_t    reply;
    // cs_n rises after three bytes
    spi_transfer(build_frame(56'haa_bbcc_ddee_ff00), 3, reply);
    expect_no_req(10, "after an aborted frame");
    payload = 56'h13_5724_6801_9bdf;
    spi_transfer(build_frame(payload), `SPI_FRAME_BYTES, reply);
    serve_host(payload);
    expect_no_req(50, "a second time after one good frame");
    check_value("crc_err_count", 64'(crc_err_count), 64'(exp_crc_errs));
    check_value("overrun_count", 64'(overrun_count), 64'(exp_overruns));
  endtask

  task automatic overrun_drop();
    spi_frame_pkg::payload_t first;
    spi_frame_pkg::payload_t second;
    spi_frame_pkg::word_t    reply;
    first  = 56'h01_0203_0405_0607;
    second = 56'hf1_f2f3_f4f5_f6f7;
    // Host holds the first frame while the second one arrives
    spi_transfer(build_frame(first), `SPI_FRAME_BYTES, reply);
    spi_transfer(build_frame(second), `SPI_FRAME_BYTES, reply);
    exp_overruns++;
    check_value("overrun_count", 64'(overrun_count), 64'(exp_overruns));
    serve_host(first);
    expect_no_req(50, "for a dropped frame");
  endtask

  task automatic random_traffic();
    spi_frame_pkg::payload_t payload;
    spi_frame_pkg::word_t    frame;
    spi_frame_pkg::word_t    reply;
    logic [63:0]             rnd;
    logic [31:0]             flip;
    int                      n;
    for (n = 0; n < 20; n++) begin
      rnd        = {$urandom, $urandom};
      payload    = rnd[55:0];
      reply_data = {$urandom, $urandom};
      frame      = build_frame(payload);
      // Roughly one frame in four gets a broken CRC
      if (($urandom % 4) == 0) begin
        flip = ($urandom % 255) + 1;
        frame[63:56] = frame[63:56] ^ flip[7:0];
        exp_crc_errs++;
        spi_transfer(frame, `SPI_FRAME_BYTES, reply);
        expect_no_req(20, "after a random frame with a bad CRC");
      end else begin
        spi_transfer(frame, `SPI_FRAME_BYTES, reply);
        serve_host(payload);
      end
      check_value("reply", reply, reply_data);
    end
    check_value("crc_err_count", 64'(crc_err_count), 64'(exp_crc_errs));
    check_value("overrun_count", 64'(overrun_count), 64'(exp_overruns));
  endtask

  initial begin
    void'($urandom(32'hfc5c));
    $timeformat(-9, 0, " ns", 0);
    errors       = 0;
    checks       = 0;
    cycle_count  = 0;
    exp_crc_errs = 0;
    exp_overruns = 0;
    resetn       = 1'b1;
    sck          = 1'b0;
    cs_n         = 1'b1;
    copi         = 1'b0;
    cmd_ack      = 1'b0;
    reply_data   = '0;
    // Reset is active high on resetn
    wait_cycles(4);
    resetn = 1'b0;
    wait_cycles(2);
    check_value("cmd_req", 64'(cmd_req), 64'd0);
    check_value("cipo", 64'(cipo), 64'd0);
    check_value("crc_err_count", 64'(crc_err_count), 64'd0);
    check_value("overrun_count", 64'(overrun_count), 64'd0);

    good_frame_flow();
    bad_crc_drop();
    aborted_frame_recovery();
    overrun_drop();
    random_traffic();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== design/spi_frame_port.sv ====
`timescale 1ns/1ps

// SPI mode 0 command port
// 8-byte frames, LSB byte first, last byte is CRC-8
module spi_frame_port (
  input  logic                    clk,
  input  logic                    resetn,

  // SPI pins
  input  logic                    sck,
  input  logic                    cs_n,
  input  logic                    copi,
  output logic                    cipo,

  // Reply word, must stay stable during a frame
  input  spi_frame_pkg::word_t    reply_data,

  // Host handshake
  output logic                    cmd_req,
  input  logic                    cmd_ack,
  output spi_frame_pkg::payload_t cmd_payload,

  // Status
  output spi_frame_pkg::count_t   crc_err_count,
  output spi_frame_pkg::count_t   overrun_count
);

  // Byte link shared by engine, assembler and CRC
  byte_link_if link ();

  spi_frame_pkg::word_t word;
  logic                 word_done;
  spi_frame_pkg::byte_t crc_residue;

  // Pin level byte transfers
  spi_byte_engine u_engine (
    .clk    (clk),
    .resetn (resetn),
    .sck    (sck),
    .cs_n   (cs_n),
    .copi   (copi),
    .cipo   (cipo),
    .link   (link.engine)
  );

  // Word assembly and reply byte selection
  frame_assembler u_assembler (
    .clk        (clk),
    .resetn     (resetn),
    .link       (link.assembler),
    .reply_data (reply_data),
    .word       (word),
    .word_done  (word_done)
  );

  // Runs alongside the assembler on the same bytes
  frame_crc u_crc (
    .clk         (clk),
    .resetn      (resetn),
    .link        (link.listen),
    .crc_residue (crc_residue)
  );

  // Frame verdict and host side
  frame_checker u_checker (
    .clk           (clk),
    .resetn        (resetn),
    .word_done     (word_done),
    .cmd_ack       (cmd_ack),
    .word          (word),
    .crc_residue   (crc_residue),
    .cmd_req       (cmd_req),
    .cmd_payload   (cmd_payload),
    .crc_err_count (crc_err_count),
    .overrun_count (overrun_count)
  );

endmodule

// ==== design/frame_checker.sv ====
`timescale 1ns/1ps

// Judges completed frames and hands good payloads to the host
// over a four-phase req/ack handshake
module frame_checker (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     word_done,
  input  logic                     cmd_ack,
  input  spi_frame_pkg::word_t     word,
  input  spi_frame_pkg::byte_t     crc_residue,
  output logic                     cmd_req,
  output spi_frame_pkg::payload_t  cmd_payload,
  output spi_frame_pkg::count_t    crc_err_count,
  output spi_frame_pkg::count_t    overrun_count
);

  spi_frame_pkg::checker_state_t state;
  spi_frame_pkg::payload_t       payload_q;

  logic crc_ok;
  logic accept;

  assign crc_ok = (crc_residue == '0);
  // Good frame and the host holds nothing
  assign accept = word_done && crc_ok && (state == spi_frame_pkg::IDLE);

  // Handshake FSM
  always_ff @(posedge clk) begin
    if (resetn) begin
      state <= spi_frame_pkg::IDLE;
    end else begin
      case (state)
        spi_frame_pkg::IDLE: begin
          if (accept) begin
            state <= spi_frame_pkg::REQ;
          end
        end
        // Wait for ack high
        spi_frame_pkg::REQ: begin
          if (cmd_ack) begin
            state <= spi_frame_pkg::RELEASE;
          end
        end
        // Req is down, wait for ack low before the next frame
        spi_frame_pkg::RELEASE: begin
          if (!cmd_ack) begin
            state <= spi_frame_pkg::IDLE;
          end
        end
        default: state <= spi_frame_pkg::IDLE;
      endcase
    end
  end

  // Payload holds steady from req rise to the next accept
  // CRC byte in the top of the word is dropped
  always_ff @(posedge clk) begin
    if (accept) begin
      payload_q <= word[$bits(spi_frame_pkg::payload_t)-1:0];
    end
  end

  // Error counters, saturating
  // a bad CRC counts only as a CRC error, even under back-pressure
  always_ff @(posedge clk) begin
    if (resetn) begin
      crc_err_count <= '0;
      overrun_count <= '0;
    end else if (word_done) begin
      if (!crc_ok) begin
        if (crc_err_count != '1) begin
          crc_err_count <= crc_err_count + 1'b1;
        end
      end else if (state != spi_frame_pkg::IDLE) begin
        if (overrun_count != '1) begin
          overrun_count <= overrun_count + 1'b1;
        end
      end
    end
  end

  assign cmd_req     = (state == spi_frame_pkg::REQ);
  assign cmd_payload = payload_q;

endmodule

// ==== design/frame_crc.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

// Running CRC-8 over all bytes of the current frame
// Residue is zero after a frame whose last byte is its own CRC
module frame_crc (
  input  logic                 clk,
  input  logic                 resetn,
  byte_link_if.listen          link,
  output spi_frame_pkg::byte_t crc_residue
);

  spi_frame_pkg::byte_t crc_q;

  // Fold one byte into the CRC, MSB first, init 0, no final XOR
  function automatic spi_frame_pkg::byte_t crc8_byte(
    input spi_frame_pkg::byte_t crc,
    input spi_frame_pkg::byte_t data
  );
    spi_frame_pkg::byte_t c;
    int                   i;
    c = crc ^ data;
    for (i = 0; i < `SPI_BYTE_W; i++) begin
      if (c[`SPI_BYTE_W-1]) begin
        c = (c << 1) ^ `SPI_CRC_POLY;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk) begin
    if (resetn) begin
      crc_q <= '0;
    end else if (!link.frame_active) begin
      // Fresh start for every frame
      crc_q <= '0;
    end else if (link.rx_valid) begin
      // Same cycle as the assembler update, so word_done lines up
      crc_q <= crc8_byte(crc_q, link.rx_byte);
    end
  end

  assign crc_residue = crc_q;

endmodule

// ==== design/frame_assembler.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

// Collects the bytes of one frame into a little-endian word
// and feeds the matching reply byte back to the engine
module frame_assembler (
  input  logic                  clk,
  input  logic                  resetn,
  byte_link_if.assembler        link,
  input  spi_frame_pkg::word_t  reply_data,
  output spi_frame_pkg::word_t  word,
  output logic                  word_done
);

  localparam spi_frame_pkg::byte_idx_t LAST_IDX =
    spi_frame_pkg::byte_idx_t'(`SPI_FRAME_BYTES - 1);

  spi_frame_pkg::byte_idx_t byte_idx;
  spi_frame_pkg::word_t     word_q;
  logic                     word_done_q;

  // Byte index, cleared whenever chip select drops
  always_ff @(posedge clk) begin
    if (resetn) begin
      byte_idx    <= '0;
      word_done_q <= 1'b0;
    end else if (!link.frame_active) begin
      byte_idx    <= '0;
      word_done_q <= 1'b0;
    end else begin
      word_done_q <= link.rx_valid && (byte_idx == LAST_IDX);
      if (link.rx_valid) begin
        // Wraps to zero after the CRC byte
        byte_idx <= byte_idx + 1'b1;
      end
    end
  end

  // New bytes enter at the top
  // after eight shifts byte 0 lands in bits 7:0
  always_ff @(posedge clk) begin
    if (link.rx_valid) begin
      word_q <= {link.rx_byte, word_q[$bits(word_q)-1:`SPI_BYTE_W]};
    end
  end

  assign word      = word_q;
  assign word_done = word_done_q;

  // Reply byte k goes out while frame byte k is in flight
  assign link.tx_byte = reply_data[byte_idx*`SPI_BYTE_W +: `SPI_BYTE_W];

endmodule

// ==== design/spi_byte_engine.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

// SPI mode 0 peripheral, 8 bit transfers, MSB first
module spi_byte_engine (
  input  logic        clk,
  input  logic        resetn,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        copi,
  output logic        cipo,
  byte_link_if.engine link
);

  localparam int CNT_W = $clog2(`SPI_BYTE_W);

  // Input synchronizers
  // sck_q[2] is only the previous synced value for edge detection
  logic [2:0]           sck_q;
  logic [1:0]           copi_q;
  logic [1:0]           cs_n_q;

  // Bit counters, receive counts up and transmit counts down
  logic [CNT_W-1:0]     rx_cnt;
  logic [CNT_W-1:0]     tx_cnt;

  spi_frame_pkg::byte_t rx_shift;
  logic                 rx_valid_q;

  logic                 sck_rise;
  logic                 sck_fall;
  logic                 cs_active;

  // Edge events in the clk domain
  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  // Chip select is active low
  assign cs_active = ~cs_n_q[1];

  always_ff @(posedge clk) begin
    if (resetn) begin
      sck_q  <= '0;
      copi_q <= '0;
      cs_n_q <= '1;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      copi_q <= {copi_q[0], copi};
      cs_n_q <= {cs_n_q[0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      rx_cnt     <= '0;
      tx_cnt     <= '1;
      rx_valid_q <= 1'b0;
    end else if (!cs_active) begin
      // Idle or interrupted transfer, restart both counts
      rx_cnt     <= '0;
      tx_cnt     <= '1;
      rx_valid_q <= 1'b0;
    end else begin
      // Pulse together with the 8th shifted bit
      rx_valid_q <= sck_rise && (rx_cnt == '1);
      if (sck_rise) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      // Wraps back to bit 7 after the last falling edge
      if (sck_fall) begin
        tx_cnt <= tx_cnt - 1'b1;
      end
    end
  end

  // Receive shift register, COPI sampled on rising SCK
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[`SPI_BYTE_W-2:0], copi_q[1]};
    end
  end

  assign link.rx_byte      = rx_shift;
  assign link.rx_valid     = rx_valid_q;
  assign link.frame_active = cs_active;

  // Raw cs_n so bit 7 is on the pin before the first SCK edge
  // Driven low rather than released while deselected
  assign cipo = cs_n ? 1'b0 : link.tx_byte[tx_cnt];

endmodule

// ==== design/byte_link_if.sv ====
`timescale 1ns/1ps

// Byte level link between the SPI engine and the frame logic
interface byte_link_if;

  // Last received byte, valid while rx_valid is high
  spi_frame_pkg::byte_t rx_byte;
  // One cycle pulse per received byte
  logic                 rx_valid;
  // Chip select asserted, already synchronized
  logic                 frame_active;
  // Byte shifted out on CIPO during the current transfer
  spi_frame_pkg::byte_t tx_byte;

  // SPI side
  modport engine (output rx_byte, rx_valid, frame_active, input tx_byte);

  // Frame assembler, also supplies the reply byte
  modport assembler (input rx_byte, rx_valid, frame_active, output tx_byte);

  // Observers such as the CRC unit
  modport listen (input rx_byte, rx_valid, frame_active);

endinterface

// ==== design/spi_frame_pkg.sv ====
`include "spi_defines.svh"

package spi_frame_pkg;

  // One SPI byte
  typedef logic [`SPI_BYTE_W-1:0] byte_t;

  // Whole frame, byte 0 sits in the low bits
  typedef logic [`SPI_FRAME_BYTES*`SPI_BYTE_W-1:0] word_t;

  // Frame without the trailing CRC byte
  typedef logic [(`SPI_FRAME_BYTES-1)*`SPI_BYTE_W-1:0] payload_t;

  // Position of a byte inside the frame
  typedef logic [$clog2(`SPI_FRAME_BYTES)-1:0] byte_idx_t;

  // Saturating error counter
  typedef logic [`SPI_COUNT_W-1:0] count_t;

  // Host handshake FSM
  typedef enum logic [1:0] {IDLE, REQ, RELEASE} checker_state_t;

endpackage

// ==== design/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Frame geometry
// Seven payload bytes followed by one CRC byte
`define SPI_FRAME_BYTES 8

// Bits per SPI transfer
`define SPI_BYTE_W 8

// CRC-8 generator x^8 + x^2 + x + 1
// Top bit is implicit, so only the low eight bits are listed
`define SPI_CRC_POLY 8'h07

// Width of the saturating error counters
`define SPI_COUNT_W 8

`endif
